// File: hdl/cdw_pkg.sv
// Shared widths, cause codes and entry layouts imported by all walker RTL modules
package cdw_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    localparam int DID_W   = 24;
    localparam int PPN_W   = 44;
    localparam int PA_W    = 56;
    localparam int CAUSE_W = 11;
    localparam int DW_W    = 64;
    // Context is tc, iohgatp, ta and fsc
    localparam int CTX_DWS = 4;

    // Fault causes reported on error_o
    localparam logic [CAUSE_W-1:0] CAUSE_DDT_INVALID = 11'd258;
    localparam logic [CAUSE_W-1:0] CAUSE_DDT_MISCONF = 11'd259;
    localparam logic [CAUSE_W-1:0] CAUSE_DDT_CORRUPT = 11'd268;

    // ddtp.MODE encodings for the directory depth
    localparam logic [3:0] MODE_1LVL = 4'd2;
    localparam logic [3:0] MODE_2LVL = 4'd3;
    localparam logic [3:0] MODE_3LVL = 4'd4;

    // Remaining directory levels, LVL1 holds the leaf
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } level_e;

    typedef logic [1:0] ctx_idx_t;

    // ------------------------------------------------------------
    // Fetched doubleword layouts
    // ------------------------------------------------------------
    // Non-leaf directory entry
    typedef struct packed {
        logic [9:0]       rsvd_hi;
        logic [PPN_W-1:0] ppn;
        logic [8:0]       rsvd_lo;
        logic             v;
    } nl_entry_t;

    // Translation control
    typedef struct packed {
        logic [31:0] rsvd_hi;
        logic [19:0] rsvd_lo;
        logic        sxl;
        logic        sbe;
        logic        dpe;
        logic        sade;
        logic        gade;
        logic        prpr;
        logic        pdtv;
        logic        dtf;
        logic        t2gpa;
        logic        en_pri;
        logic        en_ats;
        logic        v;
    } tc_t;

    // Second-stage root pointer
    typedef struct packed {
        logic [3:0]       mode;
        logic [15:0]      gscid;
        logic [PPN_W-1:0] ppn;
    } iohgatp_t;

    // Translation attributes
    typedef struct packed {
        logic [31:0] rsvd_hi;
        logic [19:0] pscid;
        logic [11:0] rsvd_lo;
    } ta_t;

    // First-stage context
    typedef struct packed {
        logic [3:0]       mode;
        logic [15:0]      rsvd;
        logic [PPN_W-1:0] ppn;
    } fsc_t;

    // One bus word, seen as a directory entry or as a context doubleword
    typedef union packed {
        nl_entry_t nl;
        tc_t       tc;
        iohgatp_t  iohgatp;
        ta_t       ta;
        fsc_t      fsc;
    } cdw_word_u;

    // Loaded device context, tc in the low doubleword
    typedef struct packed {
        fsc_t     fsc;
        ta_t      ta;
        iohgatp_t iohgatp;
        tc_t      tc;
    } dev_ctx_t;

    // Capability and feature-control bits
    typedef struct packed {
        logic t2gpa;
        logic amo_hwad;
        logic sv32;
        logic sv39;
        logic sv48;
        logic sv57;
        logic sv32x4;
        logic sv39x4;
        logic sv48x4;
        logic sv57x4;
        logic gxl;
        logic be;
    } caps_t;

endpackage

// File: hdl/cdw_walk_ctrl.sv
// Walk sequencer for the device directory; issues fetches, tracks the level and reports results
`timescale 1ns/1ps

module cdw_walk_ctrl import cdw_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_ni,
    // Miss request
    input  logic               miss_i,
    input  logic [DID_W-1:0]   did_i,
    input  logic [PPN_W-1:0]   ddtp_ppn_i,
    input  logic [3:0]         ddtp_mode_i,
    // Results of the current fetch
    input  logic               fault_i,
    input  logic [CAUSE_W-1:0] fault_cause_i,
    input  logic               fetch_done_i,
    input  logic               bus_err_i,
    input  cdw_word_u          word_i,
    input  logic               ctx_full_i,
    // Stage control
    output logic               busy_o,
    output logic               fetch_req_o,
    output logic [PA_W-1:0]    fetch_adr_o,
    output logic               leaf_o,
    output logic               ctx_store_o,
    output logic               ctx_clear_o,
    // Walk result
    output logic               update_o,
    output logic [DID_W-1:0]   did_o,
    output logic               error_o,
    output logic [CAUSE_W-1:0] cause_o
);

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        WAIT,
        ERROR
    } state_e;

    state_e             state_q, state_d;
    level_e             lvl_q, lvl_d;
    level_e             start_lvl;
    level_e             next_lvl;
    logic               mode_ok;
    logic [PA_W-1:0]    start_ptr;
    logic [PA_W-1:0]    pptr_q, pptr_d;
    logic [DID_W-1:0]   did_q, did_d;
    logic [CAUSE_W-1:0] cause_q, cause_d;

    // Table pointer for a level, indexed by its device ID slice
    // Leaf contexts are 32 bytes, non-leaf entries 8 bytes
    function automatic logic [PA_W-1:0] table_ptr(input logic [PPN_W-1:0] ppn,
                                                  input level_e lvl,
                                                  input logic [DID_W-1:0] did);
        logic [PA_W-1:0] ptr;
        case (lvl)
            LVL1:    ptr = {ppn, did[6:0], 5'b0};
            LVL2:    ptr = {ppn, did[15:7], 3'b0};
            default: ptr = {ppn, 1'b0, did[23:16], 3'b0};
        endcase
        return ptr;
    endfunction

    // ------------------------------------------------------------
    // Walk entry point from ddtp
    // ------------------------------------------------------------
    always_comb begin
        start_lvl = LVL1;
        mode_ok   = 1'b1;
        case (ddtp_mode_i)
            MODE_1LVL: start_lvl = LVL1;
            MODE_2LVL: start_lvl = LVL2;
            MODE_3LVL: start_lvl = LVL3;
            // Off, bare and reserved modes cannot be walked
            default:   mode_ok = 1'b0;
        endcase
    end

    assign start_ptr = table_ptr(ddtp_ppn_i, start_lvl, did_i);
    assign next_lvl  = level_e'(lvl_q - 2'd1);

    // First fetch goes out straight from IDLE to save a cycle
    assign fetch_adr_o = (state_q == IDLE) ? start_ptr : pptr_q;
    assign leaf_o      = (lvl_q == LVL1);

    assign busy_o  = (state_q != IDLE);
    assign error_o = (state_q == ERROR);
    assign cause_o = cause_q;
    assign did_o   = did_q;

    // ------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------
    always_comb begin
        state_d     = state_q;
        lvl_d       = lvl_q;
        pptr_d      = pptr_q;
        did_d       = did_q;
        cause_d     = cause_q;
        fetch_req_o = 1'b0;
        ctx_store_o = 1'b0;
        ctx_clear_o = 1'b0;
        update_o    = 1'b0;

        case (state_q)
            IDLE: begin
                if (miss_i) begin
                    did_d       = did_i;
                    lvl_d       = start_lvl;
                    pptr_d      = start_ptr;
                    ctx_clear_o = 1'b1;
                    if (mode_ok) begin
                        fetch_req_o = 1'b1;
                        state_d     = WAIT;
                    end else begin
                        cause_d = CAUSE_DDT_MISCONF;
                        state_d = ERROR;
                    end
                end
            end

            FETCH: begin
                // Full context means the leaf is done
                if (ctx_full_i) begin
                    update_o = 1'b1;
                    state_d  = IDLE;
                end else begin
                    fetch_req_o = 1'b1;
                    state_d     = WAIT;
                end
            end

            WAIT: begin
                if (fetch_done_i) begin
                    // Bus error wins over any decode of the returned word
                    if (bus_err_i) begin
                        cause_d = CAUSE_DDT_CORRUPT;
                        state_d = ERROR;
                    end else if (fault_i) begin
                        cause_d = fault_cause_i;
                        state_d = ERROR;
                    end else if (leaf_o) begin
                        // Next context doubleword sits 8 bytes higher
                        ctx_store_o = 1'b1;
                        pptr_d      = pptr_q + PA_W'(DW_W / 8);
                        state_d     = FETCH;
                    end else begin
                        lvl_d   = next_lvl;
                        pptr_d  = table_ptr(word_i.nl.ppn, next_lvl, did_q);
                        state_d = FETCH;
                    end
                end
            end

            // One cycle of error_o
            ERROR: state_d = IDLE;

            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            lvl_q   <= LVL1;
            cause_q <= '0;
        end else begin
            state_q <= state_d;
            lvl_q   <= lvl_d;
            cause_q <= cause_d;
        end
    end

    always_ff @(posedge clk_i) begin
        pptr_q <= pptr_d;
        did_q  <= did_d;
    end

    // Requester must hold off new misses during a walk
    a_no_miss_while_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        busy_o |-> !miss_i);

endmodule

// File: hdl/cdw_wb_fetch.sv
// Wishbone classic read master that returns one registered doubleword per fetch request
`timescale 1ns/1ps

module cdw_wb_fetch import cdw_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    // Request from the walk controller
    input  logic            fetch_req_i,
    input  logic [PA_W-1:0] fetch_adr_i,
    // Wishbone master port
    output logic            wb_cyc_o,
    output logic            wb_stb_o,
    output logic [PA_W-1:0] wb_adr_o,
    input  logic [DW_W-1:0] wb_dat_i,
    input  logic            wb_ack_i,
    input  logic            wb_err_i,
    // Registered result
    output logic            fetch_done_o,
    output logic            bus_err_o,
    output cdw_word_u       word_o
);

    logic            cyc_q;
    logic            done_q;
    logic            err_q;
    logic [PA_W-1:0] adr_q;
    cdw_word_u       word_q;

    // Classic single read, stb follows cyc
    assign wb_cyc_o     = cyc_q;
    assign wb_stb_o     = cyc_q;
    assign wb_adr_o     = adr_q;
    assign fetch_done_o = done_q;
    assign bus_err_o    = err_q;
    assign word_o       = word_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cyc_q  <= 1'b0;
            done_q <= 1'b0;
            err_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (fetch_req_i) begin
                cyc_q <= 1'b1;
            end else if (cyc_q && (wb_ack_i || wb_err_i)) begin
                // Drop the cycle and flag completion next clock
                cyc_q  <= 1'b0;
                done_q <= 1'b1;
                err_q  <= wb_err_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch_req_i) begin
            adr_q <= fetch_adr_i;
        end
        if (cyc_q && wb_ack_i) begin
            word_q <= wb_dat_i;
        end
    end

    // Wait states keep cyc, stb and the address steady
    a_hold_until_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_stb_o && !wb_ack_i && !wb_err_i |=> wb_cyc_o && wb_stb_o && $stable(wb_adr_o));

    // Only one fetch in flight at a time
    a_one_outstanding: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fetch_req_i |-> !wb_cyc_o);

endmodule

// File: hdl/cdw_entry_check.sv
// Combinational checker that validates a fetched directory entry or context doubleword
`timescale 1ns/1ps

module cdw_entry_check import cdw_pkg::*; (
    input  cdw_word_u          word_i,
    input  logic               leaf_i,
    input  ctx_idx_t           idx_i,
    input  tc_t                tc_i,
    input  caps_t              caps_i,
    output logic               fault_o,
    output logic [CAUSE_W-1:0] fault_cause_o
);

    logic invalid;
    logic misconf;

    // Paging mode legal for the XLEN setting and the given capabilities
    // 32-bit XLEN only allows the Sv32 flavour in slot 8
    function automatic logic mode_supported(input logic [3:0] mode,
                                            input logic xl, s32, s39, s48, s57);
        logic ok;
        case (mode)
            4'd0:    ok = 1'b1;
            4'd8:    ok = xl ? s32 : s39;
            4'd9:    ok = !xl && s48;
            4'd10:   ok = !xl && s57;
            default: ok = 1'b0;
        endcase
        return ok;
    endfunction

    always_comb begin
        invalid = 1'b0;
        misconf = 1'b0;

        if (!leaf_i) begin
            // ------------------------------------------------------------
            // Non-leaf directory entry
            // ------------------------------------------------------------
            invalid = !word_i.nl.v;
            misconf = (|word_i.nl.rsvd_lo) || (|word_i.nl.rsvd_hi);
        end else begin
            // ------------------------------------------------------------
            // Device context doublewords
            // ------------------------------------------------------------
            case (idx_i)
                2'd0: begin
                    invalid = !word_i.tc.v;
                    misconf = (|word_i.tc.rsvd_lo) || (|word_i.tc.rsvd_hi)
                           || (word_i.tc.t2gpa && !word_i.tc.en_ats)
                           || (word_i.tc.t2gpa && !caps_i.t2gpa)
                           // Process directories are not walked here
                           || word_i.tc.pdtv
                           || ((word_i.tc.sade || word_i.tc.gade) && !caps_i.amo_hwad)
                           || (word_i.tc.sbe != caps_i.be)
                           || (word_i.tc.sxl != caps_i.gxl);
                end
                2'd1: begin
                    // Second-stage root follows the gxl setting and x4 caps
                    misconf = !mode_supported(word_i.iohgatp.mode, caps_i.gxl,
                                              caps_i.sv32x4, caps_i.sv39x4,
                                              caps_i.sv48x4, caps_i.sv57x4)
                           // Root table is 16 KiB aligned
                           || ((|word_i.iohgatp.mode) && (|word_i.iohgatp.ppn[1:0]));
                end
                2'd2: begin
                    misconf = (|word_i.ta.rsvd_lo) || (|word_i.ta.rsvd_hi);
                end
                default: begin
                    // First stage follows sxl from the stored tc
                    misconf = !mode_supported(word_i.fsc.mode, tc_i.sxl,
                                              caps_i.sv32, caps_i.sv39,
                                              caps_i.sv48, caps_i.sv57)
                           || (|word_i.fsc.rsvd);
                end
            endcase
        end
    end

    // Invalid takes priority over misconfigured
    assign fault_o       = invalid || misconf;
    assign fault_cause_o = invalid ? CAUSE_DDT_INVALID : CAUSE_DDT_MISCONF;

endmodule

// File: hdl/cdw_context_asm.sv
// Collects the device context doublewords of a leaf fetch and flags a complete context
`timescale 1ns/1ps

module cdw_context_asm import cdw_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      ctx_clear_i,
    input  logic      ctx_store_i,
    input  cdw_word_u word_i,
    output ctx_idx_t  idx_o,
    output tc_t       tc_o,
    output dev_ctx_t  ctx_o,
    output logic      ctx_full_o
);

    // Doubleword 0 lands in the low bits, matching dev_ctx_t
    logic [CTX_DWS-1:0][DW_W-1:0] ctx_q;
    ctx_idx_t                     idx_q;
    logic                         full_q;

    assign idx_o      = idx_q;
    assign tc_o       = tc_t'(ctx_q[0]);
    assign ctx_o      = dev_ctx_t'(ctx_q);
    assign ctx_full_o = full_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            idx_q  <= '0;
            full_q <= 1'b0;
        end else if (ctx_clear_i) begin
            idx_q  <= '0;
            full_q <= 1'b0;
        end else if (ctx_store_i) begin
            idx_q <= idx_q + 2'd1;
            // Last slot written
            if (idx_q == ctx_idx_t'(CTX_DWS - 1)) begin
                full_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (ctx_store_i) begin
            ctx_q[idx_q] <= word_i;
        end
    end

    // Walker must stop storing once the context is complete
    a_no_store_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ctx_store_i |-> !full_q);

endmodule

// File: hdl/cdw_top.sv
// Top level of the device directory walker; connects control, bus fetch, checks and context storage
`timescale 1ns/1ps

module cdw_top import cdw_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_ni,
    // Miss request
    input  logic               miss_i,
    input  logic [DID_W-1:0]   did_i,
    input  logic [PPN_W-1:0]   ddtp_ppn_i,
    input  logic [3:0]         ddtp_mode_i,
    input  caps_t              caps_i,
    // Result
    output logic               busy_o,
    output logic               update_o,
    output logic [DID_W-1:0]   did_o,
    output dev_ctx_t           ctx_o,
    output logic               error_o,
    output logic [CAUSE_W-1:0] cause_o,
    // Wishbone master
    output logic               wb_cyc_o,
    output logic               wb_stb_o,
    output logic [PA_W-1:0]    wb_adr_o,
    input  logic [DW_W-1:0]    wb_dat_i,
    input  logic               wb_ack_i,
    input  logic               wb_err_i
);

    logic               fetch_req;
    logic [PA_W-1:0]    fetch_adr;
    logic               fetch_done;
    logic               bus_err;
    cdw_word_u          word;
    logic               leaf;
    logic               fault;
    logic [CAUSE_W-1:0] fault_cause;
    logic               ctx_store;
    logic               ctx_clear;
    logic               ctx_full;
    ctx_idx_t           idx;
    tc_t                tc;

    // ------------------------------------------------------------
    // Stages
    // ------------------------------------------------------------
    cdw_walk_ctrl u_walk_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .miss_i        (miss_i),
        .did_i         (did_i),
        .ddtp_ppn_i    (ddtp_ppn_i),
        .ddtp_mode_i   (ddtp_mode_i),
        .fault_i       (fault),
        .fault_cause_i (fault_cause),
        .fetch_done_i  (fetch_done),
        .bus_err_i     (bus_err),
        .word_i        (word),
        .ctx_full_i    (ctx_full),
        .busy_o        (busy_o),
        .fetch_req_o   (fetch_req),
        .fetch_adr_o   (fetch_adr),
        .leaf_o        (leaf),
        .ctx_store_o   (ctx_store),
        .ctx_clear_o   (ctx_clear),
        .update_o      (update_o),
        .did_o         (did_o),
        .error_o       (error_o),
        .cause_o       (cause_o)
    );

    cdw_wb_fetch u_wb_fetch (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .fetch_req_i  (fetch_req),
        .fetch_adr_i  (fetch_adr),
        .wb_cyc_o     (wb_cyc_o),
        .wb_stb_o     (wb_stb_o),
        .wb_adr_o     (wb_adr_o),
        .wb_dat_i     (wb_dat_i),
        .wb_ack_i     (wb_ack_i),
        .wb_err_i     (wb_err_i),
        .fetch_done_o (fetch_done),
        .bus_err_o    (bus_err),
        .word_o       (word)
    );

    cdw_entry_check u_entry_check (
        .word_i        (word),
        .leaf_i        (leaf),
        .idx_i         (idx),
        .tc_i          (tc),
        .caps_i        (caps_i),
        .fault_o       (fault),
        .fault_cause_o (fault_cause)
    );

    cdw_context_asm u_context_asm (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .ctx_clear_i (ctx_clear),
        .ctx_store_i (ctx_store),
        .word_i      (word),
        .idx_o       (idx),
        .tc_o        (tc),
        .ctx_o       (ctx_o),
        .ctx_full_o  (ctx_full)
    );

endmodule

// File: verification/tb_cdw.sv
// Self-checking testbench for the device directory walker; replays the walks in the test data file
`timescale 1ns/1ps

module tb_cdw import cdw_pkg::*; ();

    localparam int IMG_WORDS   = 256;
    // Record is {caps, mode, did}, ppn, {is_error, cause}, tc, iohgatp, ta, fsc
    localparam int REC_WORDS   = 7;
    localparam int CYC_PER_REC = 64;

    logic               clk_i;
    logic               rst_ni;
    logic               miss_i;
    logic [DID_W-1:0]   did_i;
    logic [PPN_W-1:0]   ddtp_ppn_i;
    logic [3:0]         ddtp_mode_i;
    caps_t              caps_i;
    logic               busy_o;
    logic               update_o;
    logic [DID_W-1:0]   did_o;
    dev_ctx_t           ctx_o;
    logic               error_o;
    logic [CAUSE_W-1:0] cause_o;
    logic               wb_cyc_o;
    logic               wb_stb_o;
    logic [PA_W-1:0]    wb_adr_o;
    logic [DW_W-1:0]    wb_dat_i;
    logic               wb_ack_i;
    logic               wb_err_i;

    // Header, memory image pairs, then test records
    logic [63:0] tdata [0:IMG_WORDS-1];
    int          n_pairs;
    int          n_recs;
    int          rec_base;
    int          cycle_limit;
    int          cycles;
    int          n_results;
    int          hit;
    logic [31:0] lfsr_q;
    logic        pending_q;
    logic [1:0]  wait_q;
    logic [1:0]  wait_n;

    cdw_top dut_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .miss_i      (miss_i),
        .did_i       (did_i),
        .ddtp_ppn_i  (ddtp_ppn_i),
        .ddtp_mode_i (ddtp_mode_i),
        .caps_i      (caps_i),
        .busy_o      (busy_o),
        .update_o    (update_o),
        .did_o       (did_o),
        .ctx_o       (ctx_o),
        .error_o     (error_o),
        .cause_o     (cause_o),
        .wb_cyc_o    (wb_cyc_o),
        .wb_stb_o    (wb_stb_o),
        .wb_adr_o    (wb_adr_o),
        .wb_dat_i    (wb_dat_i),
        .wb_ack_i    (wb_ack_i),
        .wb_err_i    (wb_err_i)
    );

    always #2 clk_i = ~clk_i;

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    // Fibonacci LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Image pair holding this address or -1 when unmapped
    function automatic int image_index(input logic [PA_W-1:0] adr);
        int idx;
        idx = -1;
        for (int i = 0; i < n_pairs; i++) begin
            if (tdata[2 + 2 * i][PA_W-1:0] == adr) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    task automatic fail_run();
        $display("TEST FAILED");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_ctx(input dev_ctx_t got, input dev_ctx_t exp);
        if (got !== exp) begin
            $display("ERR %0t ns: ctx_o got %h expected %h", $time, got, exp);
            fail_run();
        end
    endtask

    task automatic check_cause(input logic [CAUSE_W-1:0] got, input logic [CAUSE_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR %0t ns: cause_o got %0d expected %0d", $time, got, exp);
            fail_run();
        end
    endtask

    task automatic check_did(input logic [DID_W-1:0] got, input logic [DID_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR %0t ns: did_o got %h expected %h", $time, got, exp);
            fail_run();
        end
    endtask

    // One miss from record r, then wait for its single result pulse
    task automatic run_record(input int r);
        int          base;
        logic [63:0] cfg;
        logic        exp_err;
        dev_ctx_t    exp_ctx;
        base    = rec_base + REC_WORDS * r;
        cfg     = tdata[base];
        exp_err = tdata[base + 2][16];
        exp_ctx = {tdata[base + 6], tdata[base + 5], tdata[base + 4], tdata[base + 3]};
        while (busy_o) @(negedge clk_i);
        @(posedge clk_i);
        miss_i      <= 1'b1;
        did_i       <= cfg[DID_W-1:0];
        ddtp_mode_i <= cfg[27:24];
        caps_i      <= caps_t'(cfg[43:32]);
        ddtp_ppn_i  <= tdata[base + 1][PPN_W-1:0];
        @(posedge clk_i);
        miss_i <= 1'b0;
        do @(negedge clk_i); while (!update_o && !error_o);
        // Walk still counts as busy in its result cycle
        if (!busy_o) begin
            $display("ERR %0t ns: record %0d result pulse came with busy_o low", $time, r);
            fail_run();
        end
        if (error_o != exp_err) begin
            $display("ERR %0t ns: record %0d gave update_o=%0b error_o=%0b, expected error %0b",
                     $time, r, update_o, error_o, exp_err);
            fail_run();
        end
        if (exp_err) begin
            check_cause(cause_o, tdata[base + 2][CAUSE_W-1:0]);
        end else begin
            check_did(did_o, cfg[DID_W-1:0]);
            check_ctx(ctx_o, exp_ctx);
        end
        // Result lasts one cycle and busy_o falls right after it
        @(negedge clk_i);
        if (busy_o || update_o || error_o) begin
            $display("ERR %0t ns: record %0d result longer than one cycle or still busy",
                     $time, r);
            fail_run();
        end
    endtask

    // ------------------------------------------------------------
    // Wishbone memory model
    // ------------------------------------------------------------
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wb_ack_i  <= 1'b0;
            wb_err_i  <= 1'b0;
            wb_dat_i  <= '0;
            pending_q <= 1'b0;
            wait_q    <= '0;
        end else begin
            wb_ack_i <= 1'b0;
            wb_err_i <= 1'b0;
            if (wb_cyc_o && wb_stb_o && !wb_ack_i && !wb_err_i) begin
                if (!pending_q) begin
                    // Two LFSR bits give 0 to 3 wait states
                    for (int b = 0; b < 2; b++) begin
                        lfsr_q = lfsr_step(lfsr_q);
                        wait_n = {wait_n[0], lfsr_q[0]};
                    end
                end else begin
                    wait_n = wait_q;
                end
                if (wait_n != 2'd0) begin
                    pending_q <= 1'b1;
                    wait_q    <= wait_n - 2'd1;
                end else begin
                    pending_q <= 1'b0;
                    hit = image_index(wb_adr_o);
                    if (hit < 0) begin
                        $display("Walker read unmapped address %h", wb_adr_o);
                        fail_run();
                    end else if (tdata[2 + 2 * hit][63]) begin
                        // Marked corrupt in the image
                        wb_err_i <= 1'b1;
                    end else begin
                        wb_ack_i <= 1'b1;
                        wb_dat_i <= tdata[3 + 2 * hit];
                    end
                end
            end
        end
    end

    // Result pulse counter and overall cycle limit
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (rst_ni && update_o && error_o) begin
            $display("update_o and error_o were high in the same cycle");
            fail_run();
        end else if (rst_ni && (update_o || error_o)) begin
            n_results <= n_results + 1;
        end else if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles without finishing the records", cycles);
            fail_run();
        end
    end

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        clk_i       = 1'b0;
        rst_ni      = 1'b0;
        miss_i      = 1'b0;
        did_i       = '0;
        ddtp_ppn_i  = '0;
        ddtp_mode_i = '0;
        caps_i      = '0;
        wb_dat_i    = '0;
        wb_ack_i    = 1'b0;
        wb_err_i    = 1'b0;
        lfsr_q      = 32'hec869b66;
        cycles      = 0;
        n_results   = 0;
        cycle_limit = 0;
        $readmemh("verification/cdw_testdata.hex", tdata);
        n_pairs     = int'(tdata[0]);
        n_recs      = int'(tdata[1]);
        rec_base    = 2 + 2 * n_pairs;
        cycle_limit = n_recs * CYC_PER_REC;
        if (n_recs == 0) begin
            $display("Test data file holds no records");
            fail_run();
        end
        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        if (busy_o || update_o || error_o || wb_cyc_o || wb_stb_o) begin
            $display("ERR %0t ns: outputs not idle after reset", $time);
            fail_run();
        end
        for (int r = 0; r < n_recs; r++) begin
            run_record(r);
        end
        if (n_results != n_recs) begin
            $display("Saw %0d results for %0d misses", n_results, n_recs);
            fail_run();
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

// File: verification/cdw_testdata.hex
// Header: image pair count, record count. Image lines: address data, bit 63 of address = bus err
// Records: {caps, mode, did} ddtp_ppn {is_error, cause} tc iohgatp ta fsc
14 c
// Memory image, shared leaf context at 1000a0
1000a0 83
1000a8 8000500000001234
1000b0 abcde000
1000b8 9000000000004567
200018 40001
400010 140001
500010 40001
// Faulty non-leaf entries
200008 40000
200010 40003
// Faulty leaf contexts
1000c0 82
1000e0 483
100100 83
100108 a000500000001234
100120 83
100128 8000500000001234
100130 abcde000
100138 9000100000004567
8000000000400018 0
100140 83
8000000000100148 0
// Walks with valid entries, one, two and three levels
598_02000005 100 0 83 8000500000001234 abcde000 9000000000004567
598_03000185 200 0 83 8000500000001234 abcde000 9000000000004567
598_04020105 400 0 83 8000500000001234 abcde000 9000000000004567
// Non-leaf invalid, non-leaf reserved
598_03000085 200 1_0102 0 0 0 0
598_03000105 200 1_0103 0 0 0 0
// tc invalid, sbe mismatch, iohgatp mode, fsc reserved
598_02000006 100 1_0102 0 0 0 0
598_02000007 100 1_0103 0 0 0 0
598_02000008 100 1_0103 0 0 0 0
598_02000009 100 1_0103 0 0 0 0
// Bus err on a non-leaf and on a leaf fetch, then ddtp mode off
598_04030105 400 1_010c 0 0 0 0
598_0200000a 100 1_010c 0 0 0 0
598_00000005 100 1_0103 0 0 0 0

// File: vlog.f
hdl/cdw_pkg.sv
hdl/cdw_walk_ctrl.sv
hdl/cdw_wb_fetch.sv
hdl/cdw_entry_check.sv
hdl/cdw_context_asm.sv
hdl/cdw_top.sv
verification/tb_cdw.sv
